// ==== source/prefetch_pkg.sv ====
`default_nettype none

package prefetch_pkg;

	localparam int ADDR_WIDTH = 32;
	localparam int LINE_WIDTH = 256;
	localparam int GRACE_WIDTH = 8;
	localparam int HIT_COUNT_WIDTH = 16;
	localparam int NUM_SLOTS = 4;

	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [LINE_WIDTH-1:0] line_t;
	typedef logic [$clog2(NUM_SLOTS)-1:0] slot_idx_t;
	typedef logic [GRACE_WIDTH-1:0] grace_t;
	typedef logic [HIT_COUNT_WIDTH-1:0] hit_count_t;

	// grace limit out of reset
	localparam grace_t GRACE_DEFAULT = 8'd20;

	// L2 side, level request answered by a one-cycle resp
	typedef struct packed {
		addr_t address;
		logic read;
		logic write;
		line_t wdata;
	} l2_req_t;

	typedef struct packed {
		line_t rdata;
		logic resp;
	} l2_rsp_t;

	// pmem side, same protocol
	typedef struct packed {
		addr_t address;
		logic read;
		logic write;
		line_t wdata;
	} mem_req_t;

	typedef struct packed {
		line_t rdata;
		logic resp;
	} mem_rsp_t;

	typedef struct packed {
		logic enable;
		grace_t grace_limit;
	} cfg_t;

	typedef enum logic [2:0] {
		idle,
		prefetch,
		check_hit,
		pass_through,
		hit_reply
	} engine_state_t;

endpackage

`default_nettype wire

// ==== source/prefetch_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetch_buffer
(
	input wire clk,
	input wire prefetch_counter_reset,
	input wire prefetch_pkg::addr_t orb,
	input wire prefetch_pkg::addr_t lookup_address,
	input wire load_hint,
	input wire fill,
	input wire prefetch_pkg::line_t fill_data,
	input wire invalidate,
	input wire prefetch_pkg::slot_idx_t invalidate_index,
	output logic hit,
	output prefetch_pkg::slot_idx_t hit_index,
	output logic hit_ready,
	output prefetch_pkg::line_t hit_data,
	output logic hint_present,
	output prefetch_pkg::addr_t fill_address,
	output logic fill_pending
);

	import prefetch_pkg::*;

	addr_t slot_address [NUM_SLOTS];
	line_t slot_data [NUM_SLOTS];
	logic [NUM_SLOTS-1:0] slot_valid;
	logic [NUM_SLOTS-1:0] slot_ready;
	slot_idx_t write_ptr;
	slot_idx_t load_ptr;

	// a hint goes to the slot after the pointer, which then moves onto it
	assign load_ptr = write_ptr + slot_idx_t'(1);

	// lookup, walking down so the lowest matching slot wins
	always_comb
	begin
		hit = 1'b0;
		hit_index = '0;
		for (int i = NUM_SLOTS - 1; i >= 0; i--)
		begin
			if (slot_valid[i] && slot_address[i] == lookup_address)
			begin
				hit = 1'b1;
				hit_index = slot_idx_t'(i);
			end
		end
	end

	// duplicate hint suppression
	always_comb
	begin
		hint_present = 1'b0;
		for (int i = 0; i < NUM_SLOTS; i++)
		begin
			if (slot_valid[i] && slot_address[i] == orb)
				hint_present = 1'b1;
		end
	end

	assign hit_ready = slot_ready[hit_index];
	assign hit_data = slot_data[hit_index];

	// the pointer's slot is the one being prefetched
	assign fill_address = slot_address[write_ptr];
	assign fill_pending = slot_valid[write_ptr] & ~slot_ready[write_ptr];

	always_ff @(posedge clk)
	begin
		if (prefetch_counter_reset)
		begin
			slot_valid <= '0;
			slot_ready <= '0;
			write_ptr <= '0;
		end
		else
		begin
			if (load_hint)
			begin
				slot_valid[load_ptr] <= 1'b1;
				slot_ready[load_ptr] <= 1'b0;
				write_ptr <= load_ptr;
			end
			if (fill)
				slot_ready[write_ptr] <= 1'b1;
			// write hit, the buffered line is stale now
			if (invalidate)
				slot_ready[invalidate_index] <= 1'b0;
		end
	end

	always_ff @(posedge clk)
	begin
		if (load_hint)
			slot_address[load_ptr] <= orb;
		if (fill)
			slot_data[write_ptr] <= fill_data;
	end

endmodule

`default_nettype wire

// ==== source/prefetch_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetch_engine
(
	input wire clk,
	input wire prefetch_counter_reset,
	input wire prefetch_pkg::cfg_t cfg,
	input wire prefetch_pkg::l2_req_t l2_req,
	input wire prefetch_pkg::mem_rsp_t mem_rsp,
	input wire hit,
	input wire prefetch_pkg::slot_idx_t hit_index,
	input wire hit_ready,
	input wire prefetch_pkg::line_t hit_data,
	input wire hint_present,
	input wire prefetch_pkg::addr_t fill_address,
	input wire fill_pending,
	output prefetch_pkg::l2_rsp_t l2_rsp,
	output prefetch_pkg::mem_req_t mem_req,
	output logic load_hint,
	output logic fill,
	output logic invalidate,
	output prefetch_pkg::slot_idx_t invalidate_index,
	output logic hit_event
);

	import prefetch_pkg::*;

	engine_state_t state;
	engine_state_t next_state;
	grace_t grace_count;
	logic l2_active;
	logic within_grace;

	assign l2_active = l2_req.read | l2_req.write;
	assign within_grace = grace_count <= cfg.grace_limit;

	always_ff @(posedge clk)
	begin
		if (prefetch_counter_reset)
			state <= idle;
		else
			state <= next_state;
	end

	// elapsed prefetch cycles, held at the top so it never wraps back into grace
	always_ff @(posedge clk)
	begin
		if (prefetch_counter_reset || state != prefetch)
			grace_count <= '0;
		else if (grace_count != '1)
			grace_count <= grace_count + grace_t'(1);
	end

	// hint is taken only when the memory side is free
	assign load_hint = (state == idle) && !l2_active && cfg.enable && !hint_present;

	always_comb
	begin
		next_state = state;
		case (state)
			idle:
			begin
				if (l2_active)
					next_state = check_hit;
				else if (load_hint || fill_pending)
					next_state = prefetch;
			end
			prefetch:
			begin
				// abandon early prefetches, late ones make L2 wait
				if (l2_active && within_grace)
					next_state = check_hit;
				else if (mem_rsp.resp)
					next_state = idle;
			end
			check_hit:
			begin
				if (hit && hit_ready && l2_req.read)
					next_state = hit_reply;
				else
					next_state = pass_through;
			end
			pass_through:
			begin
				if (mem_rsp.resp)
					next_state = idle;
			end
			hit_reply:
				next_state = idle;
			default:
				next_state = idle;
		endcase
	end

	always_comb
	begin
		mem_req.address = l2_req.address;
		mem_req.read = 1'b0;
		mem_req.write = 1'b0;
		mem_req.wdata = l2_req.wdata;
		l2_rsp.rdata = mem_rsp.rdata;
		l2_rsp.resp = 1'b0;
		fill = 1'b0;
		invalidate = 1'b0;
		invalidate_index = hit_index;
		hit_event = 1'b0;
		case (state)
			prefetch:
			begin
				mem_req.address = fill_address;
				mem_req.read = 1'b1;
				// line lands in the slot even if L2 takes over this cycle
				fill = mem_rsp.resp;
			end
			check_hit:
				invalidate = hit && hit_ready && l2_req.write;
			pass_through:
			begin
				mem_req.read = l2_req.read;
				mem_req.write = l2_req.write;
				l2_rsp.resp = mem_rsp.resp;
			end
			hit_reply:
			begin
				l2_rsp.rdata = hit_data;
				l2_rsp.resp = 1'b1;
				hit_event = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/prefetch_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetch_cfg_regs
(
	input wire clk,
	input wire prefetch_counter_reset,
	input wire cfg_write,
	input wire prefetch_pkg::cfg_t cfg_wdata,
	input wire hit_event,
	output prefetch_pkg::cfg_t cfg,
	output prefetch_pkg::hit_count_t hit_count
);

	import prefetch_pkg::*;

	// enable and grace limit loaded on the write strobe
	always_ff @(posedge clk)
	begin
		if (prefetch_counter_reset)
		begin
			cfg.enable <= 1'b0;
			cfg.grace_limit <= GRACE_DEFAULT;
		end
		else if (cfg_write)
		begin
			cfg <= cfg_wdata;
		end
	end

	// buffer hit statistic that sticks at the maximum
	always_ff @(posedge clk)
	begin
		if (prefetch_counter_reset)
			hit_count <= '0;
		else if (hit_event && hit_count != '1)
			hit_count <= hit_count + hit_count_t'(1);
	end

endmodule

`default_nettype wire

// ==== source/prefetcher_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module prefetcher_top
(
	input wire clk,
	input wire prefetch_counter_reset,
	input wire prefetch_pkg::addr_t orb,
	input wire prefetch_pkg::l2_req_t l2_req,
	output prefetch_pkg::l2_rsp_t l2_rsp,
	output prefetch_pkg::mem_req_t mem_req,
	input wire prefetch_pkg::mem_rsp_t mem_rsp,
	input wire cfg_write,
	input wire prefetch_pkg::cfg_t cfg_wdata,
	output prefetch_pkg::cfg_t cfg,
	output prefetch_pkg::hit_count_t hit_count
);

	import prefetch_pkg::*;

	logic hit;
	slot_idx_t hit_index;
	logic hit_ready;
	line_t hit_data;
	logic hint_present;
	addr_t fill_address;
	logic fill_pending;
	logic load_hint;
	logic fill;
	logic invalidate;
	slot_idx_t invalidate_index;
	logic hit_event;

	prefetch_buffer buffer_i
	(
		.clk,
		.prefetch_counter_reset,
		.orb,
		// buffer is looked up with the live L2 address
		.lookup_address(l2_req.address),
		.load_hint,
		.fill,
		.fill_data(mem_rsp.rdata),
		.invalidate,
		.invalidate_index,
		.hit,
		.hit_index,
		.hit_ready,
		.hit_data,
		.hint_present,
		.fill_address,
		.fill_pending
	);

	prefetch_engine engine_i
	(
		.clk,
		.prefetch_counter_reset,
		.cfg,
		.l2_req,
		.mem_rsp,
		.hit,
		.hit_index,
		.hit_ready,
		.hit_data,
		.hint_present,
		.fill_address,
		.fill_pending,
		.l2_rsp,
		.mem_req,
		.load_hint,
		.fill,
		.invalidate,
		.invalidate_index,
		.hit_event
	);

	prefetch_cfg_regs cfg_regs_i
	(
		.clk,
		.prefetch_counter_reset,
		.cfg_write,
		.cfg_wdata,
		.hit_event,
		.cfg,
		.hit_count
	);

endmodule

`default_nettype wire

// ==== tests/pmem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module pmem_model
(
	input wire clk,
	input wire prefetch_counter_reset,
	input wire prefetch_pkg::mem_req_t mem_req,
	output prefetch_pkg::mem_rsp_t mem_rsp
);

	import prefetch_pkg::*;

	line_t lines [addr_t];
	int read_count [addr_t];
	mem_rsp_t rsp_q = '0;
	logic busy = 1'b0;
	logic respond = 1'b0;
	logic [2:0] remaining = '0;
	logic [31:0] rng_state = 32'hf0a7_bdb9;

	assign mem_rsp = rsp_q;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// unwritten lines hold their own address in every word
	function automatic line_t line_at(input addr_t address);
		if (lines.exists(address))
			return lines[address];
		return {8{address}};
	endfunction

	function automatic int reads_of(input addr_t address);
		if (read_count.exists(address))
			return read_count[address];
		return 0;
	endfunction

	always @(posedge clk)
	begin
		if (prefetch_counter_reset)
		begin
			busy <= 1'b0;
			remaining <= '0;
			rsp_q <= '0;
		end
		else
		begin
			rsp_q.resp <= 1'b0;
			respond = 1'b0;
			// a dropped request cancels, as does the resp cycle itself
			if (!(mem_req.read || mem_req.write) || rsp_q.resp)
				busy <= 1'b0;
			else if (!busy)
			begin
				// a draw of zero answers in the very next cycle
				rng_state = xorshift(rng_state);
				if (rng_state[2:0] == 3'd0)
					respond = 1'b1;
				else
				begin
					remaining <= rng_state[2:0] - 3'd1;
					busy <= 1'b1;
				end
			end
			else if (remaining != 3'd0)
				remaining <= remaining - 3'd1;
			else
				respond = 1'b1;
			if (respond)
			begin
				rsp_q.resp <= 1'b1;
				if (mem_req.write)
				begin
					lines[mem_req.address] = mem_req.wdata;
					rsp_q.rdata <= '0;
				end
				else
				begin
					read_count[mem_req.address] = reads_of(mem_req.address) + 1;
					rsp_q.rdata <= line_at(mem_req.address);
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== tests/tb_prefetcher.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_prefetcher;

	import prefetch_pkg::*;

	localparam addr_t MISS_ADDR = 32'h0000_1a40;
	localparam addr_t QUIET_HINT_ADDR = 32'h0000_2c80;
	localparam addr_t HINT_ADDR = 32'h0004_07c0;
	localparam int WAIT_LIMIT = 200;

	logic clk;
	logic prefetch_counter_reset;
	addr_t orb;
	l2_req_t l2_req;
	l2_rsp_t l2_rsp;
	mem_req_t mem_req;
	mem_rsp_t mem_rsp;
	logic cfg_write;
	cfg_t cfg_wdata;
	cfg_t cfg;
	hit_count_t hit_count;

	prefetcher_top dut_i
	(
		.clk,
		.prefetch_counter_reset,
		.orb,
		.l2_req,
		.l2_rsp,
		.mem_req,
		.mem_rsp,
		.cfg_write,
		.cfg_wdata,
		.cfg,
		.hit_count
	);

	pmem_model pmem_i
	(
		.clk,
		.prefetch_counter_reset,
		.mem_req,
		.mem_rsp
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic stop_with_failure();
		$display("Verification failed");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_value(input string test, input line_t expected, input line_t actual);
		assert (actual === expected)
		else
		begin
			$display("error %s: expected %h, actual %h", test, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic wait_cycles(input int count);
		repeat (count) @(posedge clk);
	endtask

	task automatic write_cfg(input logic enable, input grace_t limit);
		@(posedge clk);
		cfg_write <= 1'b1;
		cfg_wdata.enable <= enable;
		cfg_wdata.grace_limit <= limit;
		@(posedge clk);
		cfg_write <= 1'b0;
	endtask

	// one L2 transaction; latency counts cycles from request to resp
	task automatic l2_access(input addr_t address, input logic write, input line_t wdata,
		output line_t rdata, output int latency);
		int cycles;
		@(posedge clk);
		l2_req.address <= address;
		l2_req.read <= ~write;
		l2_req.write <= write;
		l2_req.wdata <= wdata;
		cycles = 0;
		do
		begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
			begin
				$display("timeout: no L2 response for address %h", address);
				stop_with_failure();
			end
		end
		while (!l2_rsp.resp);
		rdata = l2_rsp.rdata;
		latency = cycles - 1;
		l2_req.read <= 1'b0;
		l2_req.write <= 1'b0;
	endtask

	task automatic wait_for_read(input addr_t address);
		int cycles;
		cycles = 0;
		while (pmem_i.reads_of(address) == 0)
		begin
			@(posedge clk);
			cycles++;
			if (cycles > WAIT_LIMIT)
			begin
				$display("timeout: pmem never saw a read of %h", address);
				stop_with_failure();
			end
		end
	endtask

	task automatic check_no_traffic(input string test, input int count);
		repeat (count)
		begin
			@(posedge clk);
			assert (!mem_req.read && !mem_req.write)
			else
			begin
				$display("%s: pmem request seen while prefetching is off", test);
				stop_with_failure();
			end
		end
	endtask

	initial
	begin
		line_t rdata;
		line_t wdata;
		int latency;
		hit_count_t hits_before;
		hit_count_t hits_expected;

		prefetch_counter_reset = 1'b1;
		orb = '0;
		l2_req = '0;
		cfg_write = 1'b0;
		cfg_wdata = '0;
		repeat (5) @(posedge clk);
		prefetch_counter_reset <= 1'b0;

		@(posedge clk);
		check_value("reset", line_t'(0), line_t'(mem_req.read));
		check_value("reset", line_t'(0), line_t'(mem_req.write));
		check_value("reset", line_t'(0), line_t'(l2_rsp.resp));
		check_value("reset", line_t'(0), line_t'(hit_count));
		check_value("reset", line_t'(0), line_t'(cfg.enable));
		check_value("reset", line_t'(20), line_t'(cfg.grace_limit));

		// prefetching still off, so this goes straight to pmem
		l2_access(MISS_ADDR, 1'b0, '0, rdata, latency);
		check_value("miss", {8{MISS_ADDR}}, rdata);
		check_value("miss", line_t'(1), line_t'(pmem_i.reads_of(MISS_ADDR)));

		@(posedge clk);
		orb <= QUIET_HINT_ADDR;
		check_no_traffic("disabled", 50);

		@(posedge clk);
		orb <= HINT_ADDR;
		write_cfg(1'b1, 8'd20);
		wait_cycles(1);
		check_value("prefetch_hit", line_t'(1), line_t'(cfg.enable));
		wait_for_read(HINT_ADDR);
		wait_cycles(2);
		hits_before = hit_count;
		l2_access(HINT_ADDR, 1'b0, '0, rdata, latency);
		check_value("prefetch_hit", {8{HINT_ADDR}}, rdata);
		check_value("prefetch_hit", line_t'(2), line_t'(latency));
		wait_cycles(1);
		check_value("prefetch_hit", line_t'(1), line_t'(pmem_i.reads_of(HINT_ADDR)));
		hits_expected = hits_before + 16'd1;
		check_value("prefetch_hit", line_t'(hits_expected), line_t'(hit_count));

		// orb still points at a buffered line
		wait_cycles(50);
		check_value("duplicate", line_t'(1), line_t'(pmem_i.reads_of(HINT_ADDR)));

		hits_before = hit_count;
		wdata = ~{8{HINT_ADDR}};
		l2_access(HINT_ADDR, 1'b1, wdata, rdata, latency);
		check_value("write_invalidate", wdata, pmem_i.line_at(HINT_ADDR));
		l2_access(HINT_ADDR, 1'b0, '0, rdata, latency);
		check_value("write_invalidate", wdata, rdata);
		wait_cycles(1);
		check_value("write_invalidate", line_t'(hits_before), line_t'(hit_count));

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== files.f ====
source/prefetch_pkg.sv
source/prefetch_buffer.sv
source/prefetch_engine.sv
source/prefetch_cfg_regs.sv
source/prefetcher_top.sv
tests/pmem_model.sv
tests/tb_prefetcher.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the prefetcher testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_prefetcher -f files.f -o tb_prefetcher
./obj_dir/tb_prefetcher
